// ==== project.f ====
+incdir+logic
logic/softusb_pkg.sv
logic/softusb_line_rx.sv
logic/softusb_rx_decode.sv
logic/softusb_tx_encode.sv
logic/softusb_sie.sv
testbench/softusb_assert.sv
testbench/softusb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and decide the result from the log.
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module softusb_tb \
	-o softusb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/softusb_sim +verilator+error+limit+10 > sim.log 2>&1
cat sim.log
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

// ==== testbench/softusb_tb.sv ====
`timescale 1ns/1ps
`include "softusb_macros.svh"

module softusb_tb
	import softusb_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int DISCON_HOLD  = 200; // SE0 time on port A that exceeds the disconnect limit.
	localparam int TX_BYTES     = 15;  // SYNC, twelve random bytes, FFh and FEh.
	localparam int BYTE_CYCLES  = 10 * `SOFTUSB_CLKS_PER_BIT; // eight bits plus stuffing.
	// register polling makes the packet about eight times slower than the line.
	localparam int RUN_CYCLES     = RESET_CYCLES + DISCON_HOLD + 8 * TX_BYTES * BYTE_CYCLES;
	localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES;

	typedef logic [7:0] byte_q_t [$];

	logic       usb_clk = 1'b0;
	logic       usb_rst;
	logic       io_re;
	logic       io_we;
	logic [5:0] io_a;
	logic [7:0] io_di;
	logic [7:0] io_do;
	logic       usba_spd;
	logic       usba_oe_n;
	logic       usba_rcv;
	usb_pins_t  usba_pins_in;
	usb_pins_t  usba_pins_out;
	logic       usbb_spd;
	logic       usbb_oe_n;
	logic       usbb_rcv;
	usb_pins_t  usbb_pins_in;
	usb_pins_t  usbb_pins_out;

	int          cycles = 0;
	int          n_rx = 0;    // bytes taken from the data register.
	int          exp_idx = 0; // next expected byte for the compare process.
	logic [31:0] lfsr;
	byte_q_t     sent_q;
	byte_q_t     exp_q;
	byte_q_t     got_q;       // read bytes waiting to be compared.

	softusb_sie uut (
		.usb_clk       (usb_clk),
		.usb_rst       (usb_rst),
		.io_re         (io_re),
		.io_we         (io_we),
		.io_a          (io_a),
		.io_di         (io_di),
		.io_do         (io_do),
		.usba_spd      (usba_spd),
		.usba_oe_n     (usba_oe_n),
		.usba_rcv      (usba_rcv),
		.usba_pins_in  (usba_pins_in),
		.usba_pins_out (usba_pins_out),
		.usbb_spd      (usbb_spd),
		.usbb_oe_n     (usbb_oe_n),
		.usbb_rcv      (usbb_rcv),
		.usbb_pins_in  (usbb_pins_in),
		.usbb_pins_out (usbb_pins_out)
	);

	// port A's driver loops back into port B and a released bus idles at J.
	assign usbb_pins_in = usba_oe_n ? usb_pins_t'(LS_J) : usba_pins_out;

	always #20 usb_clk = ~usb_clk; // 40 ns period.

	always @(posedge usb_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	always @(posedge usb_clk) begin
		if (uut.sva.failed) begin
			$display("a bound assertion failed, see the error above");
			$display("RESULT: FAIL");
			$fatal(1, "assertion failure");
		end
	end

	// taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr); // one step for every bit taken.
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	// stuffing on the line must cancel, so what follows SYNC arrives unchanged.
	function automatic byte_q_t expected_rx(input byte_q_t sent);
		byte_q_t q;
		logic seen_sync;
		seen_sync = 1'b0;
		foreach (sent[i]) begin
			if (seen_sync)
				q.push_back(sent[i]);
			else if (sent[i] == 8'h80)
				seen_sync = 1'b1; // SYNC itself is never delivered.
		end
		return q;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
		@(posedge usb_clk);
		io_a  <= addr;
		io_di <= data;
		io_we <= 1'b1;
		@(posedge usb_clk); // the register file takes the write here.
		io_we <= 1'b0;
	endtask

	task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
		@(posedge usb_clk);
		io_a  <= addr;
		io_re <= 1'b1;
		@(posedge usb_clk);
		io_re <= 1'b0;
		@(negedge usb_clk); // io_do settled after the capturing edge.
		data = io_do;
	endtask

	task automatic expect_reg(input logic [5:0] addr, input logic [7:0] exp, input string what);
		logic [7:0] d;
		bus_read(addr, d);
		check({24'd0, d}, {24'd0, exp}, what);
	endtask

	// takes one received byte if one is waiting and confirms the acknowledge.
	task automatic service_rx();
		logic [7:0] pend;
		logic [7:0] data;
		bus_read(`SOFTUSB_REG_RX_PENDING, pend);
		if (pend[0]) begin
			bus_read(`SOFTUSB_REG_RX_DATA, data);
			got_q.push_back(data);
			n_rx++;
			expect_reg(`SOFTUSB_REG_RX_PENDING, 8'h00, "rx_pending after a data read");
		end
	endtask

	initial begin
		logic [7:0] got;
		forever begin
			@(posedge usb_clk);
			if (got_q.size() != 0) begin
				got = got_q.pop_front();
				check({31'd0, exp_idx < exp_q.size()}, 32'd1, "more bytes than expected");
				check({24'd0, got}, {24'd0, exp_q[exp_idx]}, $sformatf("rx byte %0d", exp_idx));
				exp_idx++;
			end
		end
	end

	initial begin
		logic [7:0] d;
		usb_rst      <= 1'b1;
		io_re        <= 1'b0;
		io_we        <= 1'b0;
		io_a         <= 6'd0;
		io_di        <= 8'd0;
		usba_rcv     <= 1'b0;
		usbb_rcv     <= 1'b0;
		usba_pins_in <= usb_pins_t'(LS_J);
		lfsr = 32'h2d49f1e5;
		repeat (RESET_CYCLES) @(posedge usb_clk);
		usb_rst <= 1'b0;

		// data registers 06h and 0Ah have no reset value; both line states idle at J.
		for (int a = 0; a < 16; a++) begin
			if (6'(a) != `SOFTUSB_REG_TX_DATA && 6'(a) != `SOFTUSB_REG_RX_DATA)
				expect_reg(6'(a), (a <= 1) ? 8'h01 : 8'h00, $sformatf("reg %02h after reset", a));
		end
		check({30'd0, usba_spd, usbb_spd}, 32'd3, "both ports report full speed");

		bus_write(`SOFTUSB_REG_PORT_SEL_RX, 8'hFF);
		expect_reg(`SOFTUSB_REG_PORT_SEL_RX, 8'h01, "port_sel_rx masked to one bit");
		bus_write(`SOFTUSB_REG_PORT_SEL_RX, 8'h02);
		expect_reg(`SOFTUSB_REG_PORT_SEL_RX, 8'h00, "port_sel_rx ignores bit 1");
		bus_write(`SOFTUSB_REG_PORT_SEL_TX, 8'hFE);
		expect_reg(`SOFTUSB_REG_PORT_SEL_TX, 8'h02, "port_sel_tx masked to two bits");
		bus_write(`SOFTUSB_REG_PORT_SEL_TX, 8'hFF);
		expect_reg(`SOFTUSB_REG_PORT_SEL_TX, 8'h03, "port_sel_tx both ports");

		// send on port A and listen on port B through the loopback.
		bus_write(`SOFTUSB_REG_PORT_SEL_TX, 8'h01);
		bus_write(`SOFTUSB_REG_PORT_SEL_RX, 8'h01);
		sent_q.push_back(8'h80);
		repeat (TX_BYTES - 3) sent_q.push_back(random_byte());
		sent_q.push_back(8'hFF); // eight ones force a stuffed bit.
		sent_q.push_back(8'hFE);
		exp_q = expected_rx(sent_q);
		foreach (sent_q[i]) begin
			bus_write(`SOFTUSB_REG_TX_DATA, sent_q[i]);
			do begin
				service_rx();
				bus_read(`SOFTUSB_REG_TX_PENDING, d);
			end while (d[0]); // the next byte waits until this one is taken.
			check({31'd0, d[1]}, 32'd0, "tx underrun while bytes came in time");
		end
		bus_write(`SOFTUSB_REG_TX_VALID, 8'h00); // no more bytes so EOP follows.
		while (n_rx < exp_q.size())
			service_rx();
		do begin
			@(negedge usb_clk);
		end while (usba_oe_n !== 1'b1);
		check({30'd0, usba_pins_out}, {30'd0, LS_J}, "port A idles at J after EOP");
		expect_reg(`SOFTUSB_REG_RX_ACTIVE, 8'h00, "rx_active after EOP");
		expect_reg(`SOFTUSB_REG_RX_PENDING, 8'h00, "rx_pending after the packet");
		expect_reg(`SOFTUSB_REG_TX_PENDING, 8'h00, "tx_pending and underrun after the packet");
		while (exp_idx < exp_q.size())
			@(posedge usb_clk);

		// a long SE0 on port A means the device is gone.
		@(posedge usb_clk);
		usba_pins_in <= usb_pins_t'(LS_SE0);
		repeat (DISCON_HOLD) @(posedge usb_clk);
		expect_reg(`SOFTUSB_REG_DISCON_A, 8'h01, "discon_a after long SE0");
		expect_reg(`SOFTUSB_REG_LINE_A, 8'h00, "line_state_a during SE0");
		@(posedge usb_clk);
		usba_pins_in <= usb_pins_t'(LS_J);
		repeat (4) @(posedge usb_clk);
		expect_reg(`SOFTUSB_REG_DISCON_A, 8'h00, "discon_a after J returns");
		expect_reg(`SOFTUSB_REG_LINE_A, 8'h01, "line_state_a back at J");

		bus_write(`SOFTUSB_REG_GEN_RESET, 8'h01);
		repeat (3) @(posedge usb_clk);
		@(negedge usb_clk);
		check({30'd0, usba_pins_out}, {30'd0, LS_SE0}, "port A pins during bus reset");
		check({31'd0, usba_oe_n}, 32'd0, "port A driven during bus reset");
		// port B is not selected for transmit and must stay released.
		check({30'd0, usbb_pins_out}, {30'd0, LS_J}, "port B pins during bus reset");
		check({31'd0, usbb_oe_n}, 32'd1, "port B released during bus reset");
		expect_reg(`SOFTUSB_REG_GEN_RESET, 8'h01, "generate_reset reads back");
		bus_write(`SOFTUSB_REG_GEN_RESET, 8'h00);
		repeat (3) @(posedge usb_clk);
		@(negedge usb_clk);
		check({30'd0, usba_pins_out}, {30'd0, LS_J}, "port A pins after bus reset");
		check({31'd0, usba_oe_n}, 32'd1, "port A released after bus reset");

		repeat (4) @(posedge usb_clk);
		if (!uut.sva.failed) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== testbench/softusb_assert.sv ====
`timescale 1ns/1ps

module softusb_assert
	import softusb_pkg::*;
(
	input logic      usb_clk,
	input logic      usb_rst,
	input tx_byte_t  tx,
	input logic      tx_ready,
	input logic      generate_reset,
	input usb_pins_t enc_pins,
	input logic      enc_oe_n,
	input logic      usba_oe_n,
	input logic      usbb_oe_n
);

	logic ready_bad = 1'b0;     // set by the first failure of each property.
	logic reset_oe_bad = 1'b0;
	logic bus_reset_bad = 1'b0;
	logic failed;               // watched from the testbench top.

	assign failed = ready_bad | reset_oe_bad | bus_reset_bad;

	// the encoder may only take a byte that the register file offers.
	ready_needs_valid: assert property (@(posedge usb_clk) disable iff (usb_rst)
		tx_ready |-> tx.valid)
		else begin
			ready_bad = 1'b1;
			$error("tx_ready was high while tx.valid was low");
		end

	// both ports stay released from the first reset edge on.
	oe_released_in_reset: assert property (@(posedge usb_clk)
		usb_rst |=> (usba_oe_n && usbb_oe_n))
		else begin
			reset_oe_bad = 1'b1;
			$error("a port drove the bus during reset");
		end

	// bus reset shows SE0 with the driver on, one cycle after the register is set.
	se0_during_bus_reset: assert property (@(posedge usb_clk) disable iff (usb_rst)
		generate_reset |=> (enc_pins == usb_pins_t'(LS_SE0)) && !enc_oe_n)
		else begin
			bus_reset_bad = 1'b1;
			$error("encoder did not drive SE0 while generate_reset was set");
		end

endmodule

bind softusb_sie softusb_assert sva (
	.usb_clk        (usb_clk),
	.usb_rst        (usb_rst),
	.tx             (tx),
	.tx_ready       (tx_ready),
	.generate_reset (generate_reset),
	.enc_pins       (enc_pins),
	.enc_oe_n       (enc_oe_n),
	.usba_oe_n      (usba_oe_n),
	.usbb_oe_n      (usbb_oe_n)
);

// ==== logic/softusb_sie.sv ====
`timescale 1ns/1ps
`include "softusb_macros.svh"

module softusb_sie
	import softusb_pkg::*;
(
	input  logic       usb_clk,
	input  logic       usb_rst,

	input  logic       io_re,
	input  logic       io_we,
	input  logic [5:0] io_a,
	input  logic [7:0] io_di,
	output logic [7:0] io_do,

	output logic       usba_spd,
	output logic       usba_oe_n,
	input  logic       usba_rcv,
	input  usb_pins_t  usba_pins_in,
	output usb_pins_t  usba_pins_out,

	output logic       usbb_spd,
	output logic       usbb_oe_n,
	input  logic       usbb_rcv,
	input  usb_pins_t  usbb_pins_in,
	output usb_pins_t  usbb_pins_out
);

	line_state_t line_state_a;
	line_state_t line_state_b;
	line_state_t rx_line_state;
	logic discon_a;
	logic discon_b;

	logic       port_sel_rx;  // 0 listens on port A, 1 on port B.
	logic [1:0] port_sel_tx;  // one enable bit per port.

	tx_byte_t  tx;
	logic      tx_ready;
	logic      tx_pending;
	logic      tx_underrun;   // a byte went out twice because none was written in time.
	logic      generate_reset;

	rx_byte_t  rx;
	logic [7:0] data_in;
	logic      rx_pending;

	usb_pins_t enc_pins;
	logic      enc_oe_n;

	assign usba_spd = 1'b1; // full speed only.
	assign usbb_spd = 1'b1;

	assign rx_line_state = port_sel_rx ? line_state_b : line_state_a;

	// ports that are not selected stay released and show idle.
	assign usba_pins_out = port_sel_tx[0] ? enc_pins : usb_pins_t'(LS_J);
	assign usba_oe_n     = port_sel_tx[0] ? enc_oe_n : 1'b1;
	assign usbb_pins_out = port_sel_tx[1] ? enc_pins : usb_pins_t'(LS_J);
	assign usbb_oe_n     = port_sel_tx[1] ? enc_oe_n : 1'b1;

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			port_sel_rx    <= 1'b0;
			port_sel_tx    <= 2'b00;
			tx.valid       <= 1'b0;
			tx_pending     <= 1'b0;
			tx_underrun    <= 1'b0;
			generate_reset <= 1'b0;
			rx_pending     <= 1'b0;
			io_do          <= 8'd0;
		end else begin
			// read data is registered, so it follows io_a by one cycle.
			case (io_a)
				`SOFTUSB_REG_LINE_A:      io_do <= {6'd0, line_state_a};
				`SOFTUSB_REG_LINE_B:      io_do <= {6'd0, line_state_b};
				`SOFTUSB_REG_DISCON_A:    io_do <= {7'd0, discon_a};
				`SOFTUSB_REG_DISCON_B:    io_do <= {7'd0, discon_b};
				`SOFTUSB_REG_PORT_SEL_RX: io_do <= {7'd0, port_sel_rx};
				`SOFTUSB_REG_PORT_SEL_TX: io_do <= {6'd0, port_sel_tx};
				`SOFTUSB_REG_TX_DATA:     io_do <= tx.data;
				`SOFTUSB_REG_TX_PENDING:  io_do <= {6'd0, tx_underrun, tx_pending};
				`SOFTUSB_REG_TX_VALID:    io_do <= {7'd0, tx.valid};
				`SOFTUSB_REG_GEN_RESET:   io_do <= {7'd0, generate_reset};
				`SOFTUSB_REG_RX_DATA: begin
					io_do <= data_in;
					if (io_re)
						rx_pending <= 1'b0; // a read of the byte acknowledges it.
				end
				`SOFTUSB_REG_RX_PENDING:  io_do <= {7'd0, rx_pending};
				`SOFTUSB_REG_RX_ACTIVE:   io_do <= {7'd0, rx.active};
				default:                  io_do <= 8'd0;
			endcase

			// encoder took the byte. An empty register here means an underrun.
			if (tx_ready) begin
				tx_pending <= 1'b0;
				if (!tx_pending)
					tx_underrun <= 1'b1;
			end

			// writes come after tx_ready so a byte written in the same cycle is kept.
			if (io_we) begin
				case (io_a)
					`SOFTUSB_REG_PORT_SEL_RX: port_sel_rx <= io_di[0];
					`SOFTUSB_REG_PORT_SEL_TX: port_sel_tx <= io_di[1:0];
					`SOFTUSB_REG_TX_DATA: begin
						tx.data     <= io_di;
						tx.valid    <= 1'b1;
						tx_pending  <= 1'b1;
						tx_underrun <= 1'b0;
					end
					`SOFTUSB_REG_TX_VALID:    tx.valid <= 1'b0; // last byte, EOP follows.
					`SOFTUSB_REG_GEN_RESET:   generate_reset <= io_di[0];
					default: ;
				endcase
			end

			// a new byte wins over a read acknowledge in the same cycle.
			if (rx.strobe) begin
				data_in    <= rx.data;
				rx_pending <= 1'b1;
			end
		end
	end

	softusb_line_rx line_rx_a (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.pins       (usba_pins_in),
		.line_state (line_state_a),
		.discon     (discon_a)
	);

	softusb_line_rx line_rx_b (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.pins       (usbb_pins_in),
		.line_state (line_state_b),
		.discon     (discon_b)
	);

	softusb_rx_decode rx_decode (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.line_state (rx_line_state),
		.rx         (rx)
	);

	softusb_tx_encode tx_encode (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.tx             (tx),
		.generate_reset (generate_reset),
		.tx_ready       (tx_ready),
		.pins           (enc_pins),
		.oe_n           (enc_oe_n)
	);

endmodule

// ==== logic/softusb_tx_encode.sv ====
`timescale 1ns/1ps
`include "softusb_macros.svh"

module softusb_tx_encode
	import softusb_pkg::*;
(
	input  logic      usb_clk,
	input  logic      usb_rst,
	input  tx_byte_t  tx,
	input  logic      generate_reset,
	output logic      tx_ready,
	output usb_pins_t pins,
	output logic      oe_n
);

	typedef enum logic [2:0] {
		ST_IDLE,  // bus released, pins at J.
		ST_DATA,  // sending a data bit.
		ST_STUFF, // sending an inserted zero.
		ST_EOP,   // two bits of SE0 then one bit of J.
		ST_RESET  // SE0 for as long as bus reset is asked for.
	} tx_state_t;

	localparam int TMR_W = $clog2(`SOFTUSB_CLKS_PER_BIT);
	localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`SOFTUSB_CLKS_PER_BIT - 1);

	tx_state_t state;
	logic [TMR_W-1:0] bit_tmr;
	logic [7:0] sreg;    // bits still to send sit at the bottom.
	logic [3:0] nbits;   // how many of them are left.
	logic [2:0] ones;    // run of ones sent so far.
	logic       level;   // current NRZI level, 1 is J.
	logic [1:0] eop_cnt;
	logic bit_end;
	logic need_stuff;
	logic byte_done;
	logic start;
	logic reload;
	logic send_bit;
	logic next_level;

	// J for a high level and K for a low one.
	function automatic usb_pins_t line_drive(input logic lvl);
		return lvl ? usb_pins_t'(LS_J) : usb_pins_t'(LS_K);
	endfunction

	assign bit_end    = (bit_tmr == TMR_LAST);
	assign need_stuff = (state == ST_DATA) && (ones == 3'd6);
	assign byte_done  = (nbits == 4'd0);

	// first byte of a packet, taken straight from idle.
	assign start = (state == ST_IDLE) && tx.valid;

	// next byte, taken at the end of the last bit of the previous one.
	// with no fresh write the old byte goes out again, which the register file flags.
	assign reload = ((state == ST_DATA) || (state == ST_STUFF)) && bit_end &&
		!need_stuff && byte_done && tx.valid;

	assign tx_ready = !generate_reset && (start || reload);

	// a new byte sends its bit 0 at once, otherwise the shifter's lowest bit goes.
	assign send_bit   = tx_ready ? tx.data[0] : sreg[0];
	assign next_level = send_bit ? level : ~level; // a zero toggles the line.

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state   <= ST_IDLE;
			bit_tmr <= '0;
			ones    <= '0;
			level   <= 1'b1;
			pins    <= usb_pins_t'(LS_J);
			oe_n    <= 1'b1;
		end else if (generate_reset) begin
			// bus reset overrides anything in flight.
			state   <= ST_RESET;
			bit_tmr <= '0;
			pins    <= usb_pins_t'(LS_SE0);
			oe_n    <= 1'b0;
		end else begin
			// the timer sits at zero in idle so the first bit gets full length.
			bit_tmr <= (state == ST_IDLE || bit_end) ? '0 : bit_tmr + 1'b1;

			case (state)
				ST_IDLE: begin
					if (start) begin
						level <= next_level;
						pins  <= line_drive(next_level);
						ones  <= send_bit ? ones + 1'b1 : 3'd0;
						sreg  <= {1'b0, tx.data[7:1]};
						nbits <= 4'd7;
						oe_n  <= 1'b0; // drive the port from the first bit.
						state <= ST_DATA;
					end
				end
				ST_DATA, ST_STUFF: begin
					if (bit_end) begin
						if (need_stuff) begin
							level <= ~level; // the inserted zero.
							pins  <= line_drive(~level);
							ones  <= '0;
							state <= ST_STUFF;
						end else if (!byte_done || reload) begin
							level <= next_level;
							pins  <= line_drive(next_level);
							ones  <= send_bit ? ones + 1'b1 : 3'd0;
							sreg  <= reload ? {1'b0, tx.data[7:1]} : {1'b0, sreg[7:1]};
							nbits <= reload ? 4'd7 : nbits - 1'b1;
							state <= ST_DATA;
						end else begin
							pins    <= usb_pins_t'(LS_SE0);
							eop_cnt <= '0;
							state   <= ST_EOP;
						end
					end
				end
				ST_EOP: begin
					if (bit_end) begin
						if (eop_cnt == 2'd1) begin
							pins    <= usb_pins_t'(LS_J); // after two SE0 bits.
							level   <= 1'b1;
							eop_cnt <= 2'd2;
						end else if (eop_cnt == 2'd2) begin
							oe_n  <= 1'b1; // J bit done, let go of the bus.
							ones  <= '0;
							state <= ST_IDLE;
						end else begin
							eop_cnt <= eop_cnt + 1'b1;
						end
					end
				end
				ST_RESET: begin
					// only reached once generate_reset has dropped.
					pins  <= usb_pins_t'(LS_J);
					oe_n  <= 1'b1;
					level <= 1'b1;
					ones  <= '0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/softusb_rx_decode.sv ====
`timescale 1ns/1ps
`include "softusb_macros.svh"

module softusb_rx_decode
	import softusb_pkg::*;
(
	input  logic        usb_clk,
	input  logic        usb_rst,
	input  line_state_t line_state,
	output rx_byte_t    rx
);

	// the phase counter wraps on its own, which needs a power of two bit length.
	localparam int PHASE_W = $clog2(`SOFTUSB_CLKS_PER_BIT);
	localparam logic [PHASE_W-1:0] SAMPLE_AT = PHASE_W'(`SOFTUSB_CLKS_PER_BIT / 2);
	localparam logic [7:0] SYNC_PATTERN = 8'h80; // seven zeros then a one, LSB first.

	line_state_t prev_state;  // line state one cycle ago, for edge detection.
	line_state_t last_level;  // J or K seen at the previous sample point.
	logic [PHASE_W-1:0] phase;
	logic is_data;
	logic edge_seen;
	logic sample;
	logic rx_bit;
	logic [7:0] hunt;         // last eight decoded bits while searching for SYNC.
	logic [7:0] hunt_next;
	logic [7:0] shreg;        // byte being assembled, filled from the top.
	logic [2:0] bit_cnt;      // data bits already in shreg.
	logic [2:0] ones;         // run of ones, the seventh bit after six is a stuff bit.

	assign is_data = (line_state == LS_J) || (line_state == LS_K);

	// only a J/K change carries timing, SE0 at the end of a packet does not.
	assign edge_seen = is_data && (line_state != prev_state);

	// the bit middle lies two cycles after its leading edge.
	assign sample = !edge_seen && (phase == SAMPLE_AT);

	assign rx_bit = (line_state == last_level); // NRZI, no change is a one.
	assign hunt_next = {rx_bit, hunt[7:1]};

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			prev_state <= LS_J;
			last_level <= LS_J;
			phase      <= '0;
			hunt       <= '1;
			ones       <= '0;
			bit_cnt    <= '0;
			rx.strobe  <= 1'b0;
			rx.active  <= 1'b0;
		end else begin
			prev_state <= line_state;
			rx.strobe  <= 1'b0; // strobe lasts a single cycle.

			// restart the bit on each edge, else free-run across runs of ones.
			phase <= edge_seen ? PHASE_W'(1) : phase + 1'b1;

			if (sample) begin
				if (line_state == LS_SE0 || line_state == LS_SE1) begin
					// end of packet, a partial byte is dropped.
					rx.active  <= 1'b0;
					hunt       <= '1;
					last_level <= LS_J; // the bus returns to J after EOP.
				end else if (!rx.active) begin
					last_level <= line_state;
					hunt       <= hunt_next;
					if (hunt_next == SYNC_PATTERN) begin
						rx.active <= 1'b1;
						bit_cnt   <= '0;
						ones      <= 3'd1; // the SYNC's last one counts toward stuffing.
					end
				end else if (ones == 3'd6) begin
					// this is the stuffed zero, it carries no data.
					last_level <= line_state;
					ones       <= '0;
				end else begin
					last_level <= line_state;
					shreg      <= {rx_bit, shreg[7:1]};
					bit_cnt    <= bit_cnt + 1'b1;
					ones       <= rx_bit ? ones + 1'b1 : 3'd0;
					if (bit_cnt == 3'd7) begin
						rx.data   <= {rx_bit, shreg[7:1]}; // eighth bit completes the byte.
						rx.strobe <= 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== logic/softusb_line_rx.sv ====
`timescale 1ns/1ps
`include "softusb_macros.svh"

module softusb_line_rx
	import softusb_pkg::*;
(
	input  logic        usb_clk,
	input  logic        usb_rst,
	input  usb_pins_t   pins,
	output line_state_t line_state,
	output logic        discon
);

	localparam int CNT_W = $clog2(`SOFTUSB_DISCON_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SOFTUSB_DISCON_CYCLES - 1);

	usb_pins_t sync_q1; // first stage, may go metastable.
	usb_pins_t sync_q2; // second stage, safe to use.
	logic [CNT_W-1:0] se0_cnt;

	// the second flop feeds the decoder, so line state lags the pins by two cycles.
	assign line_state = line_state_t'({sync_q2.vm, sync_q2.vp});

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			sync_q1 <= usb_pins_t'(LS_J); // start from idle so no false SE0 is seen.
			sync_q2 <= usb_pins_t'(LS_J);
			se0_cnt <= '0;
			discon  <= 1'b0;
		end else begin
			sync_q1 <= pins;
			sync_q2 <= sync_q1;

			// a device pulls one line high, so a long SE0 means nothing is attached.
			if (line_state == LS_SE0) begin
				if (se0_cnt == CNT_LAST) begin
					discon <= 1'b1; // counter parks here until SE0 ends.
				end else begin
					se0_cnt <= se0_cnt + 1'b1;
				end
			end else begin
				// any J, K or SE1 means something is driving the port.
				se0_cnt <= '0;
				discon  <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/softusb_pkg.sv ====
package softusb_pkg;

	// bus state of one port, coded as {vm, vp}.
	typedef enum logic [1:0] {
		LS_SE0 = 2'b00, // both lines low, reset or end of packet.
		LS_J   = 2'b01, // idle level at full speed.
		LS_K   = 2'b10,
		LS_SE1 = 2'b11  // illegal on a healthy bus.
	} line_state_t;

	// the two single-ended lines of a port.
	// vp sits in bit 0 so that a cast to line_state_t reads directly.
	typedef struct packed {
		logic vm;
		logic vp;
	} usb_pins_t;

	// byte handed from the register file to the transmit encoder.
	typedef struct packed {
		logic       valid; // firmware still has bytes for this packet.
		logic [7:0] data;
	} tx_byte_t;

	// byte handed from the receive decoder to the register file.
	typedef struct packed {
		logic       active; // high between SYNC and EOP.
		logic       strobe; // one cycle, data is a complete byte.
		logic [7:0] data;
	} rx_byte_t;

endpackage

// ==== logic/softusb_macros.svh ====
`ifndef SOFTUSB_MACROS_SVH
`define SOFTUSB_MACROS_SVH

// full speed at 48 MHz gives four usb_clk cycles per bit.
`define SOFTUSB_CLKS_PER_BIT 4

// a port counts as gone once SE0 has lasted this many cycles.
`define SOFTUSB_DISCON_CYCLES 128

// register map of the byte-wide microcontroller bus.
`define SOFTUSB_REG_LINE_A      6'h00
`define SOFTUSB_REG_LINE_B      6'h01
`define SOFTUSB_REG_DISCON_A    6'h02
`define SOFTUSB_REG_DISCON_B    6'h03
`define SOFTUSB_REG_PORT_SEL_RX 6'h04
`define SOFTUSB_REG_PORT_SEL_TX 6'h05
`define SOFTUSB_REG_TX_DATA     6'h06
`define SOFTUSB_REG_TX_PENDING  6'h07 // bit 1 holds the underrun flag.
`define SOFTUSB_REG_TX_VALID    6'h08
`define SOFTUSB_REG_GEN_RESET   6'h09
`define SOFTUSB_REG_RX_DATA     6'h0A
`define SOFTUSB_REG_RX_PENDING  6'h0B
`define SOFTUSB_REG_RX_ACTIVE   6'h0C

`endif
